//--- axis_link_pkg.sv
// Chip-to-chip link types
// Beat layout with piggybacked credits and the channel encoding

`include "noc_bridge_cfg.svh"

package axis_link_pkg;

  typedef logic [`NB_CRED_W-1:0] credit_t;

  // Virtual channel tag
  typedef enum logic {
    VC_REQ = 1'b0,
    VC_RSP = 1'b1
  } vc_e;

  // One link beat, 23 bits
  typedef struct packed {
    vc_e                      data_vc;
    noc_flit_pkg::flit_data_t data;
    logic                     data_valid;  // clear on a credit-only beat
    vc_e                      cred_vc;
    credit_t                  credits;
  } link_pkt_t;

endpackage

//--- bridge_link_top.sv
// Back-to-back bridge pair
// Side A and side B joined through their link ports

`timescale 1ns/1ps

module bridge_link_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Side A
  input  noc_flit_pkg::noc_flit_t noc_req_a_i,
  output logic                    noc_req_ready_a_o,
  input  noc_flit_pkg::noc_flit_t noc_rsp_a_i,
  output logic                    noc_rsp_ready_a_o,
  output noc_flit_pkg::noc_flit_t noc_req_a_o,
  input  logic                    noc_req_ready_a_i,
  output noc_flit_pkg::noc_flit_t noc_rsp_a_o,
  input  logic                    noc_rsp_ready_a_i,
  // Side B
  input  noc_flit_pkg::noc_flit_t noc_req_b_i,
  output logic                    noc_req_ready_b_o,
  input  noc_flit_pkg::noc_flit_t noc_rsp_b_i,
  output logic                    noc_rsp_ready_b_o,
  output noc_flit_pkg::noc_flit_t noc_req_b_o,
  input  logic                    noc_req_ready_b_i,
  output noc_flit_pkg::noc_flit_t noc_rsp_b_o,
  input  logic                    noc_rsp_ready_b_i
);

  import axis_link_pkg::*;

  // A to B and B to A link wires
  link_pkt_t link_ab;
  logic      link_valid_ab;
  logic      link_ready_ab;
  link_pkt_t link_ba;
  logic      link_valid_ba;
  logic      link_ready_ba;

  vc_axis_bridge u_side_a (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .noc_req_i       (noc_req_a_i),
    .noc_req_ready_o (noc_req_ready_a_o),
    .noc_rsp_i       (noc_rsp_a_i),
    .noc_rsp_ready_o (noc_rsp_ready_a_o),
    .noc_req_o       (noc_req_a_o),
    .noc_req_ready_i (noc_req_ready_a_i),
    .noc_rsp_o       (noc_rsp_a_o),
    .noc_rsp_ready_i (noc_rsp_ready_a_i),
    .link_o          (link_ab),
    .link_valid_o    (link_valid_ab),
    .link_ready_i    (link_ready_ab),
    .link_i          (link_ba),
    .link_valid_i    (link_valid_ba),
    .link_ready_o    (link_ready_ba)
  );

  vc_axis_bridge u_side_b (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .noc_req_i       (noc_req_b_i),
    .noc_req_ready_o (noc_req_ready_b_o),
    .noc_rsp_i       (noc_rsp_b_i),
    .noc_rsp_ready_o (noc_rsp_ready_b_o),
    .noc_req_o       (noc_req_b_o),
    .noc_req_ready_i (noc_req_ready_b_i),
    .noc_rsp_o       (noc_rsp_b_o),
    .noc_rsp_ready_i (noc_rsp_ready_b_i),
    .link_o          (link_ba),
    .link_valid_o    (link_valid_ba),
    .link_ready_i    (link_ready_ba),
    .link_i          (link_ab),
    .link_valid_i    (link_valid_ab),
    .link_ready_o    (link_ready_ab)
  );

endmodule

//--- credit_sync.sv
// Per-channel credit synchronizer
// Tracks send credits toward the far queue and pending return credits,
// holds one accepted flit and requests credit-only beats at the threshold

`timescale 1ns/1ps
`include "noc_bridge_cfg.svh"

module credit_sync (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // NoC input
  input  noc_flit_pkg::noc_flit_t   in_flit_i,
  output logic                      in_ready_o,
  // Toward the arbiter
  output logic                      out_valid_o,
  output noc_flit_pkg::flit_data_t  out_data_o,
  output logic                      out_cred_only_o,
  input  logic                      out_ready_i,
  // Return credits for the local receive queue
  output axis_link_pkg::credit_t    pending_o,
  input  logic                      rx_pop_i,
  input  logic                      cred_take_i,
  input  axis_link_pkg::credit_t    cred_take_amt_i,
  // Credits coming back from the far side
  input  logic                      cred_rx_valid_i,
  input  axis_link_pkg::credit_t    cred_rx_i
);

  import noc_flit_pkg::*;
  import axis_link_pkg::*;

  credit_t    send_q;
  credit_t    send_d;
  credit_t    pend_q;
  credit_t    pend_d;
  logic       hold_valid_q;
  flit_data_t hold_data_q;
  logic       accept;
  logic       hold_pop;
  logic       force_cred;

  //////////////////////////////
  // Admission and hold stage
  //////////////////////////////

  // Hold slot frees in the same cycle the arbiter takes it
  assign hold_pop   = hold_valid_q & out_ready_i;
  assign in_ready_o = (send_q != '0) & (~hold_valid_q | out_ready_i);
  assign accept     = in_flit_i.valid & in_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      hold_valid_q <= 1'b0;
    end else if (accept) begin
      hold_valid_q <= 1'b1;
    end else if (hold_pop) begin
      hold_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      hold_data_q <= in_flit_i.data;
    end
  end

  // No data waiting but enough credits piled up
  assign force_cred      = ~hold_valid_q & (pend_q >= credit_t'(`NB_FORCE_THRESH));
  assign out_valid_o     = hold_valid_q | force_cred;
  assign out_cred_only_o = ~hold_valid_q;
  assign out_data_o      = hold_data_q;

  //////////////////////////////
  // Credit counters
  //////////////////////////////

  always_comb begin
    send_d = send_q;
    if (accept) begin
      send_d = send_d - credit_t'(1);
    end
    if (cred_rx_valid_i) begin
      send_d = send_d + cred_rx_i;
    end
  end

  always_comb begin
    pend_d = pend_q;
    if (rx_pop_i) begin
      pend_d = pend_d + credit_t'(1);
    end
    if (cred_take_i) begin
      pend_d = pend_d - cred_take_amt_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      send_q <= credit_t'(`NB_NUM_CRED);
      pend_q <= '0;
    end else begin
      send_q <= send_d;
      pend_q <= pend_d;
    end
  end

  assign pending_o = pend_q;

  // A link beat takes no more return credits than are pending
  a_pend_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cred_take_i |-> (cred_take_amt_i <= pend_q))
    else $error("credit_sync pending counter taken below zero");

  // Far side must never return more than it was given
  a_send_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    send_q <= credit_t'(`NB_NUM_CRED))
    else $error("credit_sync send counter above NB_NUM_CRED");

endmodule

//--- noc_bridge_cfg.svh
// NoC bridge configuration
// Payload width, credit depth and credit-only force level

`ifndef NOC_BRIDGE_CFG_SVH
`define NOC_BRIDGE_CFG_SVH

// Flit payload width in bits
`define NB_DATA_W 16

// Receive queue depth, also the credit count after reset
`define NB_NUM_CRED 8

// Wide enough for 0 to NB_NUM_CRED
`define NB_CRED_W 4

// Pending return credits that trigger a credit-only beat
`define NB_FORCE_THRESH 4

`endif

//--- noc_flit_pkg.sv
// NoC flit types
// One flit layout shared by the request and response channels

`include "noc_bridge_cfg.svh"

package noc_flit_pkg;

  // Payload carried by a single flit
  typedef logic [`NB_DATA_W-1:0] flit_data_t;

  // Flit with its valid bit, the ready travels beside it
  typedef struct packed {
    logic       valid;
    flit_data_t data;
  } noc_flit_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
  --top-module tb_bridge_link -o sim_bridge_link
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_bridge_link 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "TESTS PASSED"; then
  exit 0
else
  exit 1
fi

//--- sources.f
+incdir+.
noc_flit_pkg.sv
axis_link_pkg.sv
stream_fifo.sv
credit_sync.sv
vc_rr_arbiter.sv
vc_axis_bridge.sv
bridge_link_top.sv
tb_bridge_link.sv

//--- stream_fifo.sv
// Valid/ready FIFO
// Circular buffer with a fill count and the output taken straight from storage

`timescale 1ns/1ps

module stream_fifo #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 2
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign ready_o = (count != CNT_W'(DEPTH));
  assign valid_o = (count != '0);
  assign data_o  = mem[rd_ptr];
  assign push    = valid_i & ready_o;
  assign pop     = valid_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // A push refused while full stays offered until it is taken
  a_full_push_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i && !ready_o |=> valid_i)
    else $error("stream_fifo input dropped a push while full");

endmodule

//--- tb_bridge_link.sv
// Testbench for the back-to-back bridge pair
// Drives both NoC sides, keeps per-channel expected queues and
// checks every delivered flit in order

`timescale 1ns/1ps
`include "noc_bridge_cfg.svh"

module tb_bridge_link;

  import noc_flit_pkg::*;

  localparam int WAIT_LIMIT  = 1000;
  localparam int DRAIN_LIMIT = 4000;
  localparam int BLOCK_CYC   = 40;

  logic        clk;
  logic        rst_n;
  logic [31:0] rng_state;
  bit          traffic_done;

  // Index 0 A to B request, 1 A to B response, 2 B to A request, 3 B to A response
  noc_flit_t in_flit [4];
  logic      in_ready [4];
  noc_flit_t out_flit [4];
  logic      out_ready [4];

  flit_data_t exp_ab_req[$];
  flit_data_t exp_ab_rsp[$];
  flit_data_t exp_ba_req[$];
  flit_data_t exp_ba_rsp[$];
  flit_data_t exp_data;

  bridge_link_top UUT (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .noc_req_a_i       (in_flit[0]),
    .noc_req_ready_a_o (in_ready[0]),
    .noc_rsp_a_i       (in_flit[1]),
    .noc_rsp_ready_a_o (in_ready[1]),
    .noc_req_a_o       (out_flit[2]),
    .noc_req_ready_a_i (out_ready[2]),
    .noc_rsp_a_o       (out_flit[3]),
    .noc_rsp_ready_a_i (out_ready[3]),
    .noc_req_b_i       (in_flit[2]),
    .noc_req_ready_b_o (in_ready[2]),
    .noc_rsp_b_i       (in_flit[3]),
    .noc_rsp_ready_b_o (in_ready[3]),
    .noc_req_b_o       (out_flit[0]),
    .noc_req_ready_b_i (out_ready[0]),
    .noc_rsp_b_o       (out_flit[1]),
    .noc_rsp_ready_b_i (out_ready[1])
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic fail_now(input string line);
    $display("%s", line);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic string chan_name(input int ch);
    case (ch)
      0: return "A-to-B request";
      1: return "A-to-B response";
      2: return "B-to-A request";
      default: return "B-to-A response";
    endcase
  endfunction

  function automatic void push_expected(input int ch, input flit_data_t d);
    case (ch)
      0: exp_ab_req.push_back(d);
      1: exp_ab_rsp.push_back(d);
      2: exp_ba_req.push_back(d);
      default: exp_ba_rsp.push_back(d);
    endcase
  endfunction

  // Each channel delivers its accepted flits in order
  function automatic flit_data_t expected_flit(input int ch);
    flit_data_t d;
    d = '0;
    case (ch)
      0: d = exp_ab_req.pop_front();
      1: d = exp_ab_rsp.pop_front();
      2: d = exp_ba_req.pop_front();
      default: d = exp_ba_rsp.pop_front();
    endcase
    return d;
  endfunction

  function automatic int queued(input logic [3:0] mask);
    int n;
    n = 0;
    if (mask[0]) n += exp_ab_req.size();
    if (mask[1]) n += exp_ab_rsp.size();
    if (mask[2]) n += exp_ba_req.size();
    if (mask[3]) n += exp_ba_rsp.size();
    return n;
  endfunction

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  // Entered and left 1 ns after a rising edge
  task automatic send_flits(input int ch, input int count, input int max_gap);
    int         gap;
    int         waited;
    bit         taken;
    flit_data_t d;
    for (int i = 0; i < count; i++) begin
      gap = next_rand() % (max_gap + 1);
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      d = flit_data_t'(next_rand());
      in_flit[ch] = '{valid: 1'b1, data: d};
      waited = 0;
      taken = 1'b0;
      while (!taken) begin
        @(negedge clk);
        if (in_ready[ch]) begin
          taken = 1'b1;
        end else begin
          waited++;
          assert (waited < WAIT_LIMIT)
            else fail_now($sformatf("Timeout waiting for input ready on %s", chan_name(ch)));
        end
      end
      push_expected(ch, d);
      @(posedge clk);
      #1;
      in_flit[ch].valid = 1'b0;
    end
  endtask

  // Keep valid high until ready stays low for BLOCK_CYC cycles
  task automatic fill_until_blocked(input int ch, output int accepted);
    int         blocked;
    int         cycles;
    flit_data_t d;
    accepted = 0;
    blocked = 0;
    cycles = 0;
    d = flit_data_t'(next_rand());
    in_flit[ch] = '{valid: 1'b1, data: d};
    while (blocked < BLOCK_CYC) begin
      @(negedge clk);
      cycles++;
      assert (cycles < WAIT_LIMIT)
        else fail_now($sformatf("Timeout filling credits on %s", chan_name(ch)));
      if (in_ready[ch]) begin
        push_expected(ch, d);
        accepted++;
        blocked = 0;
        @(posedge clk);
        #1;
        d = flit_data_t'(next_rand());
        in_flit[ch].data = d;
      end else begin
        blocked++;
      end
    end
    @(posedge clk);
    #1;
    in_flit[ch].valid = 1'b0;
  endtask

  task automatic wait_empty(input logic [3:0] mask);
    int waited;
    waited = 0;
    while (queued(mask) != 0) begin
      @(negedge clk);
      waited++;
      assert (waited < DRAIN_LIMIT)
        else fail_now($sformatf("Timeout with %0d flits still undelivered", queued(mask)));
    end
    @(posedge clk);
    #1;
  endtask

  // Random output back-pressure until the traffic is done
  task automatic shake_ready(input int max_cycles);
    int cycles;
    cycles = 0;
    while (!traffic_done) begin
      for (int k = 0; k < 4; k++) begin
        out_ready[k] = (next_rand() % 3) != 0;
      end
      @(posedge clk);
      #1;
      cycles++;
      assert (cycles < max_cycles)
        else fail_now("Random traffic phase did not finish in time");
    end
    for (int k = 0; k < 4; k++) begin
      out_ready[k] = 1'b1;
    end
  endtask

  //////////////////////////////
  // Output comparison
  //////////////////////////////

  // Values at the falling edge decide the transfer on the next rising edge
  always @(negedge clk) begin
    if (rst_n) begin
      for (int k = 0; k < 4; k++) begin
        if (out_flit[k].valid && out_ready[k]) begin
          assert (queued(4'b0001 << k) != 0)
            else fail_now($sformatf("%s output delivered a flit that was never sent",
                                    chan_name(k)));
          exp_data = expected_flit(k);
          assert (out_flit[k].data == exp_data)
            else fail_now($sformatf("FAILED at %0t: %s got %h, expected %h", $time,
                                    chan_name(k), out_flit[k].data, exp_data));
        end
      end
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int accepted;
    rng_state = 32'd78;
    traffic_done = 1'b0;
    rst_n = 1'b0;
    for (int k = 0; k < 4; k++) begin
      in_flit[k] = '0;
      out_ready[k] = 1'b1;
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Idle state after reset
    @(negedge clk);
    for (int k = 0; k < 4; k++) begin
      assert (!out_flit[k].valid && in_ready[k])
        else fail_now($sformatf("FAILED at %0t: %s not idle after reset", $time,
                                chan_name(k)));
    end
    @(posedge clk);
    #1;

    // With B request output stalled A may only use its initial credits
    out_ready[0] = 1'b0;
    fork
      fill_until_blocked(0, accepted);
      send_flits(1, 30, 2);
    join
    assert (accepted == `NB_NUM_CRED)
      else fail_now($sformatf("FAILED at %0t: %0d request flits accepted, expected %0d",
                              $time, accepted, `NB_NUM_CRED));
    // Responses still get through
    wait_empty(4'b0010);
    @(negedge clk);
    assert (!in_ready[0] && out_flit[0].valid && out_flit[0].data == exp_ab_req[0])
      else fail_now("Request channel did not stay blocked with its first flit held at B");
    @(posedge clk);
    #1;

    // Release so B drains and returns credits on credit-only beats
    out_ready[0] = 1'b1;
    wait_empty(4'b0001);
    send_flits(0, 24, 1);
    wait_empty(4'b0001);

    // Both directions, both channels at once
    fork
      send_flits(0, 40, 3);
      send_flits(1, 40, 3);
      send_flits(2, 40, 3);
      send_flits(3, 40, 3);
    join
    wait_empty(4'hF);

    // Long random run with random back-pressure
    fork
      begin
        fork
          send_flits(0, 150, 4);
          send_flits(1, 150, 4);
          send_flits(2, 150, 4);
          send_flits(3, 150, 4);
        join
        traffic_done = 1'b1;
      end
      shake_ready(30000);
    join
    wait_empty(4'hF);

    // No stray output and no lost credits once everything drained
    repeat (10) @(posedge clk);
    @(negedge clk);
    for (int k = 0; k < 4; k++) begin
      assert (!out_flit[k].valid && in_ready[k])
        else fail_now($sformatf("%s did not return to idle after the traffic drained",
                                chan_name(k)));
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- vc_axis_bridge.sv
// Virtual-channel link bridge
// Merges request and response flits onto one credit-controlled link and
// splits the incoming link into two receive queues

`timescale 1ns/1ps
`include "noc_bridge_cfg.svh"

module vc_axis_bridge (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // NoC inputs
  input  noc_flit_pkg::noc_flit_t  noc_req_i,
  output logic                     noc_req_ready_o,
  input  noc_flit_pkg::noc_flit_t  noc_rsp_i,
  output logic                     noc_rsp_ready_o,
  // NoC outputs
  output noc_flit_pkg::noc_flit_t  noc_req_o,
  input  logic                     noc_req_ready_i,
  output noc_flit_pkg::noc_flit_t  noc_rsp_o,
  input  logic                     noc_rsp_ready_i,
  // Link
  output axis_link_pkg::link_pkt_t link_o,
  output logic                     link_valid_o,
  input  logic                     link_ready_i,
  input  axis_link_pkg::link_pkt_t link_i,
  input  logic                     link_valid_i,
  output logic                     link_ready_o
);

  import noc_flit_pkg::*;
  import axis_link_pkg::*;

  localparam int LINK_W = $bits(link_pkt_t);

  credit_t    pend_req;
  credit_t    pend_rsp;
  vc_e        cred_vc;
  credit_t    cred_amt;
  logic       req_valid;
  logic       rsp_valid;
  logic       req_gnt;
  logic       rsp_gnt;
  logic       req_cred_only;
  logic       rsp_cred_only;
  flit_data_t req_data;
  flit_data_t rsp_data;
  link_pkt_t  req_pkt;
  link_pkt_t  rsp_pkt;
  link_pkt_t  arb_pkt;
  logic       arb_valid;
  logic       arb_ready;
  logic       beat_sent;
  logic       beat_rx;
  logic       rxq_req_push;
  logic       rxq_req_ready;
  logic       rxq_rsp_push;
  logic       rxq_rsp_ready;
  logic       rxq_req_valid;
  logic       rxq_rsp_valid;
  flit_data_t rxq_req_data;
  flit_data_t rxq_rsp_data;

  //////////////////////////////
  // Transmit path
  //////////////////////////////

  // Larger pending count rides along, response wins a tie
  assign cred_vc  = (pend_req > pend_rsp) ? VC_REQ : VC_RSP;
  assign cred_amt = (cred_vc == VC_REQ) ? pend_req : pend_rsp;

  assign beat_sent = arb_valid & arb_ready;
  assign beat_rx   = link_valid_i & link_ready_o;

  credit_sync u_sync_req (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .in_flit_i       (noc_req_i),
    .in_ready_o      (noc_req_ready_o),
    .out_valid_o     (req_valid),
    .out_data_o      (req_data),
    .out_cred_only_o (req_cred_only),
    .out_ready_i     (req_gnt),
    .pending_o       (pend_req),
    .rx_pop_i        (rxq_req_valid & noc_req_ready_i),
    .cred_take_i     (beat_sent & (arb_pkt.cred_vc == VC_REQ)),
    .cred_take_amt_i (arb_pkt.credits),
    .cred_rx_valid_i (beat_rx & (link_i.cred_vc == VC_REQ)),
    .cred_rx_i       (link_i.credits)
  );

  credit_sync u_sync_rsp (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .in_flit_i       (noc_rsp_i),
    .in_ready_o      (noc_rsp_ready_o),
    .out_valid_o     (rsp_valid),
    .out_data_o      (rsp_data),
    .out_cred_only_o (rsp_cred_only),
    .out_ready_i     (rsp_gnt),
    .pending_o       (pend_rsp),
    .rx_pop_i        (rxq_rsp_valid & noc_rsp_ready_i),
    .cred_take_i     (beat_sent & (arb_pkt.cred_vc == VC_RSP)),
    .cred_take_amt_i (arb_pkt.credits),
    .cred_rx_valid_i (beat_rx & (link_i.cred_vc == VC_RSP)),
    .cred_rx_i       (link_i.credits)
  );

  assign req_pkt = '{data_vc: VC_REQ, data: req_data, data_valid: ~req_cred_only,
                     cred_vc: cred_vc, credits: cred_amt};
  assign rsp_pkt = '{data_vc: VC_RSP, data: rsp_data, data_valid: ~rsp_cred_only,
                     cred_vc: cred_vc, credits: cred_amt};

  vc_rr_arbiter u_arb (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid),
    .req_pkt_i   (req_pkt),
    .rsp_valid_i (rsp_valid),
    .rsp_pkt_i   (rsp_pkt),
    .req_gnt_o   (req_gnt),
    .rsp_gnt_o   (rsp_gnt),
    .out_valid_o (arb_valid),
    .out_pkt_o   (arb_pkt),
    .out_ready_i (arb_ready)
  );

  // Output register keeps the link stable under back-pressure
  stream_fifo #(
    .WIDTH (LINK_W),
    .DEPTH (2)
  ) u_link_out (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (arb_valid),
    .ready_o (arb_ready),
    .data_i  (arb_pkt),
    .valid_o (link_valid_o),
    .ready_i (link_ready_i),
    .data_o  (link_o)
  );

  //////////////////////////////
  // Receive path
  //////////////////////////////

  assign rxq_req_push = link_valid_i & link_i.data_valid & (link_i.data_vc == VC_REQ);
  assign rxq_rsp_push = link_valid_i & link_i.data_valid & (link_i.data_vc == VC_RSP);

  // Credit-only beats are taken at once
  assign link_ready_o = (rxq_req_push & rxq_req_ready) | (rxq_rsp_push & rxq_rsp_ready)
                      | (link_valid_i & ~link_i.data_valid);

  stream_fifo #(
    .WIDTH (`NB_DATA_W),
    .DEPTH (`NB_NUM_CRED)
  ) u_rxq_req (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (rxq_req_push),
    .ready_o (rxq_req_ready),
    .data_i  (link_i.data),
    .valid_o (rxq_req_valid),
    .ready_i (noc_req_ready_i),
    .data_o  (rxq_req_data)
  );

  stream_fifo #(
    .WIDTH (`NB_DATA_W),
    .DEPTH (`NB_NUM_CRED)
  ) u_rxq_rsp (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (rxq_rsp_push),
    .ready_o (rxq_rsp_ready),
    .data_i  (link_i.data),
    .valid_o (rxq_rsp_valid),
    .ready_i (noc_rsp_ready_i),
    .data_o  (rxq_rsp_data)
  );

  assign noc_req_o.valid = rxq_req_valid;
  assign noc_req_o.data  = rxq_req_data;
  assign noc_rsp_o.valid = rxq_rsp_valid;
  assign noc_rsp_o.data  = rxq_rsp_data;

  a_link_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    link_valid_o && !link_ready_i |=> link_valid_o && $stable(link_o))
    else $error("vc_axis_bridge link output changed while stalled");

endmodule

//--- vc_rr_arbiter.sv
// Two-input round-robin arbiter for link packets
// Priority flips after each grant and the choice is locked while the output stalls

`timescale 1ns/1ps

module vc_rr_arbiter (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    req_valid_i,
  input  axis_link_pkg::link_pkt_t req_pkt_i,
  input  logic                    rsp_valid_i,
  input  axis_link_pkg::link_pkt_t rsp_pkt_i,
  output logic                    req_gnt_o,
  output logic                    rsp_gnt_o,
  output logic                    out_valid_o,
  output axis_link_pkg::link_pkt_t out_pkt_o,
  input  logic                    out_ready_i
);

  import axis_link_pkg::*;

  vc_e  sel;
  vc_e  prio_q;
  vc_e  lock_sel_q;
  logic lock_q;

  always_comb begin
    if (lock_q) begin
      sel = lock_sel_q;
    end else if (req_valid_i && rsp_valid_i) begin
      sel = prio_q;
    end else begin
      sel = rsp_valid_i ? VC_RSP : VC_REQ;
    end
  end

  assign out_valid_o = req_valid_i | rsp_valid_i;
  assign out_pkt_o   = (sel == VC_RSP) ? rsp_pkt_i : req_pkt_i;
  assign req_gnt_o   = out_ready_i & req_valid_i & (sel == VC_REQ);
  assign rsp_gnt_o   = out_ready_i & rsp_valid_i & (sel == VC_RSP);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prio_q     <= VC_REQ;
      lock_q     <= 1'b0;
      lock_sel_q <= VC_REQ;
    end else begin
      lock_q     <= out_valid_o & ~out_ready_i;
      lock_sel_q <= sel;
      // Other channel goes first next time
      if (out_valid_o && out_ready_i) begin
        prio_q <= (sel == VC_REQ) ? VC_RSP : VC_REQ;
      end
    end
  end

  // Every accepted output beat belongs to exactly one granted channel
  a_onehot_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && out_ready_i |-> $onehot({req_gnt_o, rsp_gnt_o}))
    else $error("vc_rr_arbiter output beat without a single grant");

  a_stall_keeps_vc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_pkt_o.data_vc))
    else $error("vc_rr_arbiter changed channel while stalled");

endmodule
